/* branchPredictUnit.f */
common/predictorPkg.sv
common/busPkg.sv
common/wbBus.sv
predictorTable/immediatePredictor.sv
verilog/busArbiter.sv
verilog/fetchLookup.sv
verilog/branchTrainer.sv
verilog/branchPredictUnit.sv
tb/branchPredictUnit_assertions.sv
tb/branchPredictUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module branchPredictUnitTb \
    -f branchPredictUnit.f \
    -o simv

./obj_dir/simv | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

/* tb/branchPredictUnitTb.sv */
`timescale 1ns/1ps

module branchPredictUnitTb;
    import predictorPkg::*;

    localparam int opCount = 700;   // lookups plus updates over all tests.
    localparam int timeoutCycles = opCount * 20;

    logic clk;
    logic rstN;
    logic lookupValid;
    branchAddrT lookupAddr;
    logic lookupReady;
    logic predValid;
    logic predTaken;
    counterT predCounter;
    logic updateValid;
    branchAddrT updateAddr;
    logic updateTaken;
    logic updateReady;

    logic [15:0] lfsr = 16'd5773;
    counterT modelMem [64];
    logic checkEnable;
    logic updPending;
    branchAddrT updAddrReg;
    logic updTakenReg;
    branchAddrT lkAddrReg;
    int errorCount = 0;
    int checkCount = 0;
    int testErrors = 0;
    int cycleCount = 0;
    int updatesDone = 0;
    int lookupsDone = 0;

    branchPredictUnit DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // saturating 2-bit counter step.
    function automatic counterT refCounter(counterT cur, logic taken);
        if (taken) begin
            return (cur == 2'b11) ? cur : cur + 2'd1;
        end
        return (cur == 2'b00) ? cur : cur - 2'd1;
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsrStep(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic randomBits(input int n, output logic [5:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            value = {value[4:0], lfsr[0]};
        end
    endtask

    task automatic checkCounter(input string name, input counterT got, input counterT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkTaken(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic doLookup(input branchAddrT addr);
        @(negedge clk);
        while (!lookupReady) @(negedge clk);
        lookupValid = 1'b1;
        lookupAddr = addr;
        @(negedge clk);
        lookupValid = 1'b0;
        while (!predValid) begin
            if (lookupReady) begin
                errorCount++;
                $display("lookupReady high at %0t while a lookup is in flight", $time);
            end
            @(negedge clk);
        end
        @(negedge clk);   // let the monitor compare first.
    endtask

    task automatic doUpdate(input branchAddrT addr, input logic taken);
        @(negedge clk);
        while (!updateReady) @(negedge clk);
        updateValid = 1'b1;
        updateAddr = addr;
        updateTaken = taken;
        @(negedge clk);
        updateValid = 1'b0;
        while (!updateReady) @(negedge clk);
    endtask

    task automatic finishTest(input string name);
        $display("test %s done, %0d errors", name, errorCount - testErrors);
        testErrors = errorCount;
    endtask

    // model update, then compare, then capture the next lookup.
    always @(posedge clk) begin
        if (updPending && updateReady) begin
            modelMem[updAddrReg] = refCounter(modelMem[updAddrReg], updTakenReg);
            updPending = 1'b0;
            updatesDone++;
        end
        if (updateValid && updateReady) begin
            updAddrReg = updateAddr;
            updTakenReg = updateTaken;
            updPending = 1'b1;
        end
        if (predValid) begin
            lookupsDone++;
        end
        if (predValid && checkEnable) begin
            checkCounter("predCounter", predCounter, modelMem[lkAddrReg]);
            checkTaken("predTaken", predTaken, modelMem[lkAddrReg][1]);
        end
        if (lookupValid && lookupReady) begin
            lkAddrReg = lookupAddr;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout after %0d cycles, a handshake never completed", cycleCount);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        logic [5:0] bits;
        branchAddrT addr;
        int waitCycles;

        rstN = 1'b0;
        lookupValid = 1'b0;
        lookupAddr = '0;
        updateValid = 1'b0;
        updateAddr = '0;
        updateTaken = 1'b0;
        checkEnable = 1'b1;
        updPending = 1'b0;
        for (int i = 0; i < 64; i++) begin
            modelMem[i] = 2'b10;   // weakly taken.
        end
        repeat (3) @(negedge clk);
        rstN = 1'b1;

        for (int a = 0; a < 64; a++) begin
            doLookup(branchAddrT'(a));
        end
        finishTest("resetState");

        repeat (3) doUpdate(6'd42, 1'b1);
        doLookup(6'd42);
        checkCounter("predCounter", predCounter, 2'b11);
        repeat (4) doUpdate(6'd42, 1'b0);
        doLookup(6'd42);
        checkCounter("predCounter", predCounter, 2'b00);
        doUpdate(6'd42, 1'b0);
        doLookup(6'd42);
        checkCounter("predCounter", predCounter, 2'b00);
        finishTest("saturation");

        repeat (2) doUpdate(6'd29, 1'b0);   // line 3, entry 5.
        for (int e = 0; e < 8; e++) begin
            doLookup(branchAddrT'(24 + e));
        end
        for (int l = 0; l < 8; l++) begin
            doLookup(branchAddrT'(l * 8 + 5));
        end
        finishTest("entryIsolation");

        for (int i = 0; i < 200; i++) begin
            randomBits(6, bits);
            addr = bits;
            randomBits(1, bits);
            doUpdate(addr, bits[0]);
            randomBits(6, bits);
            doLookup(bits);
        end
        finishTest("randomSequence");

        checkEnable = 1'b0;   // order against updates is open here.
        updatesDone = 0;
        lookupsDone = 0;
        fork
            for (int i = 0; i < 50; i++) begin
                randomBits(6, bits);
                addr = bits;
                randomBits(1, bits);
                doUpdate(addr, bits[0]);
            end
            for (int i = 0; i < 50; i++) begin
                doLookup(branchAddrT'(i * 5));
            end
        join
        @(negedge clk);   // last model update lands at the next edge.
        if (updatesDone != 50 || lookupsDone != 50) begin
            errorCount++;
            $display("contention: %0d updates and %0d lookups completed, expected 50 each",
                updatesDone, lookupsDone);
        end
        checkEnable = 1'b1;
        for (int a = 0; a < 64; a++) begin
            doLookup(branchAddrT'(a));
        end
        finishTest("contention");

        @(negedge clk);
        while (!updateReady) @(negedge clk);
        updateValid = 1'b1;
        updateAddr = 6'd12;
        updateTaken = 1'b1;
        @(negedge clk);
        updateAddr = 6'd50;   // second update held on the port.
        updateTaken = 1'b0;
        waitCycles = 0;
        while (!updateReady) begin
            @(negedge clk);
            waitCycles++;
        end
        if (waitCycles < 3) begin
            errorCount++;
            $display("updateReady rose %0d cycles after accept, before the write", waitCycles);
        end
        @(negedge clk);
        updateValid = 1'b0;
        while (!updateReady) @(negedge clk);
        doLookup(6'd12);
        doLookup(6'd50);
        finishTest("backPressure");

        $display("tests 6, checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb/branchPredictUnit_assertions.sv */
`timescale 1ns/1ps

module branchPredictUnitAssertions (
    input logic clk,
    input logic rstN,
    input logic tableAck,
    input logic lookupCyc,
    input logic lookupStb,
    input logic lookupAck,
    input predictorPkg::branchAddrT lookupAdr,
    input logic trainCyc,
    input logic trainStb,
    input logic trainAck,
    input predictorPkg::branchAddrT trainAdr,
    input logic predValid
);

    // the table's answer belongs to exactly one owner.
    oneGrant: assert property (@(posedge clk) disable iff (!rstN)
        tableAck |-> (lookupAck != trainAck))
        else $error("table ack not routed to exactly one master");

    ackNeedsCyc: assert property (@(posedge clk) disable iff (!rstN)
        (lookupAck -> lookupCyc) && (trainAck -> trainCyc))
        else $error("ack given to a master without cyc");

    // address held until the slave answers.
    lookupAdrStable: assert property (@(posedge clk) disable iff (!rstN)
        lookupStb && !lookupAck |=> $stable(lookupAdr))
        else $error("lookup adr changed while waiting for ack");

    trainAdrStable: assert property (@(posedge clk) disable iff (!rstN)
        trainStb && !trainAck |=> $stable(trainAdr))
        else $error("trainer adr changed while waiting for ack");

    predPulse: assert property (@(posedge clk) disable iff (!rstN)
        predValid |=> !predValid)
        else $error("predValid longer than one cycle");

endmodule

bind branchPredictUnit branchPredictUnitAssertions uAssertions (
    .clk(clk),
    .rstN(rstN),
    .tableAck(tableBus.ack),
    .lookupCyc(lookupBus.cyc),
    .lookupStb(lookupBus.stb),
    .lookupAck(lookupBus.ack),
    .lookupAdr(lookupBus.adr),
    .trainCyc(trainBus.cyc),
    .trainStb(trainBus.stb),
    .trainAck(trainBus.ack),
    .trainAdr(trainBus.adr),
    .predValid(predValid)
);

/* verilog/branchPredictUnit.sv */
`timescale 1ns/1ps

module branchPredictUnit (
    input  logic clk,
    input  logic rstN,
    input  logic lookupValid,
    input  predictorPkg::branchAddrT lookupAddr,
    output logic lookupReady,
    output logic predValid,
    output logic predTaken,
    output predictorPkg::counterT predCounter,
    input  logic updateValid,
    input  predictorPkg::branchAddrT updateAddr,
    input  logic updateTaken,
    output logic updateReady
);

    wbBus lookupBus ();
    wbBus trainBus ();
    wbBus tableBus ();

    fetchLookup uFetchLookup (
        .clk(clk),
        .rstN(rstN),
        .lookupValid(lookupValid),
        .lookupAddr(lookupAddr),
        .lookupReady(lookupReady),
        .predValid(predValid),
        .predTaken(predTaken),
        .predCounter(predCounter),
        .bus(lookupBus.master)
    );

    branchTrainer uBranchTrainer (
        .clk(clk),
        .rstN(rstN),
        .updateValid(updateValid),
        .updateAddr(updateAddr),
        .updateTaken(updateTaken),
        .updateReady(updateReady),
        .bus(trainBus.master)
    );

    busArbiter uBusArbiter (
        .clk(clk),
        .rstN(rstN),
        .lookupBus(lookupBus.slave),
        .trainBus(trainBus.slave),
        .tableBus(tableBus.master)
    );

    immediatePredictor uImmediatePredictor (
        .clk(clk),
        .rstN(rstN),
        .bus(tableBus.slave)
    );

endmodule

/* verilog/branchTrainer.sv */
`timescale 1ns/1ps

module branchTrainer (
    input  logic clk,
    input  logic rstN,
    input  logic updateValid,
    input  predictorPkg::branchAddrT updateAddr,
    input  logic updateTaken,
    output logic updateReady,
    wbBus.master bus
);
    import predictorPkg::*;

    logic full;
    branchAddrT addrReg;
    logic takenReg;

    // buffer frees only once the write is acked.
    assign updateReady = !full;

    assign bus.cyc = full;
    assign bus.stb = full;
    assign bus.we = 1'b1;
    assign bus.adr = addrReg;
    assign bus.datW = {1'b0, takenReg};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            full <= 1'b0;
        end else begin
            if (full && bus.ack) begin
                full <= 1'b0;
            end else if (updateValid && updateReady) begin
                full <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (updateValid && updateReady) begin
            addrReg <= updateAddr;
            takenReg <= updateTaken;
        end
    end

endmodule

/* verilog/fetchLookup.sv */
`timescale 1ns/1ps

module fetchLookup (
    input  logic clk,
    input  logic rstN,
    input  logic lookupValid,
    input  predictorPkg::branchAddrT lookupAddr,
    output logic lookupReady,
    output logic predValid,
    output logic predTaken,
    output predictorPkg::counterT predCounter,
    wbBus.master bus
);
    import predictorPkg::*;

    logic busy;
    branchAddrT adrReg;

    assign lookupReady = !busy;

    // one read cycle per accepted lookup.
    assign bus.cyc = busy;
    assign bus.stb = busy;
    assign bus.we = 1'b0;
    assign bus.adr = adrReg;
    assign bus.datW = '0;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            predValid <= 1'b0;
        end else begin
            predValid <= busy && bus.ack;
            if (busy && bus.ack) begin
                busy <= 1'b0;
            end else if (lookupValid && lookupReady) begin
                busy <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookupValid && lookupReady) begin
            adrReg <= lookupAddr;
        end
        if (busy && bus.ack) begin
            predCounter <= bus.datR;
        end
    end

    assign predTaken = predCounter[1];   // upper bit set means taken.

endmodule

/* verilog/busArbiter.sv */
`timescale 1ns/1ps

module busArbiter (
    input logic clk,
    input logic rstN,
    wbBus.slave lookupBus,
    wbBus.slave trainBus,
    wbBus.master tableBus
);
    import busPkg::*;

    arbStateT state;
    masterIdT lastServed;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= idle;
            lastServed <= masterTrainer;   // lookup wins the first tie.
        end else begin
            case (state)
                idle: begin
                    if (lookupBus.cyc && (!trainBus.cyc || lastServed == masterTrainer)) begin
                        state <= grantLookup;
                        lastServed <= masterLookup;
                    end else if (trainBus.cyc) begin
                        state <= grantTrainer;
                        lastServed <= masterTrainer;
                    end
                end
                grantLookup: begin
                    if (!lookupBus.cyc) begin
                        state <= idle;
                    end
                end
                grantTrainer: begin
                    if (!trainBus.cyc) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_comb begin
        tableBus.cyc = 1'b0;
        tableBus.stb = 1'b0;
        tableBus.we = 1'b0;
        tableBus.adr = lookupBus.adr;
        tableBus.datW = lookupBus.datW;
        case (state)
            grantLookup: begin
                tableBus.cyc = lookupBus.cyc;
                tableBus.stb = lookupBus.stb;
                tableBus.we = lookupBus.we;
            end
            grantTrainer: begin
                tableBus.cyc = trainBus.cyc;
                tableBus.stb = trainBus.stb;
                tableBus.we = trainBus.we;
                tableBus.adr = trainBus.adr;
                tableBus.datW = trainBus.datW;
            end
            default: ;
        endcase
    end

    // only the owner sees the response.
    assign lookupBus.ack = (state == grantLookup) && tableBus.ack;
    assign trainBus.ack = (state == grantTrainer) && tableBus.ack;
    assign lookupBus.datR = (state == grantLookup) ? tableBus.datR : '0;
    assign trainBus.datR = (state == grantTrainer) ? tableBus.datR : '0;

endmodule

/* predictorTable/immediatePredictor.sv */
`timescale 1ns/1ps

module immediatePredictor (
    input logic clk,
    input logic rstN,
    wbBus.slave bus
);
    import predictorPkg::*;

    lineSelT lineSel;
    entrySelT entrySel;
    lineT lineRegs [lineCount];
    counterT curCounter;
    counterT nextCounter;
    logic access;
    logic writeHit;

    // upper bits pick the line, lower bits the entry.
    assign lineSel = bus.adr[lookupAddrBits-1 -: lineSelBits];
    assign entrySel = bus.adr[entrySelBits-1:0];

    assign curCounter = lineRegs[lineSel][entrySel];

    // new request, not the tail of one already acked.
    assign access = bus.cyc && bus.stb && !bus.ack;
    assign writeHit = access && bus.we;

    // saturating 2-bit update.
    always_comb begin
        nextCounter = curCounter;
        if (bus.datW[0]) begin
            if (curCounter != counterStrongTaken) begin
                nextCounter = curCounter + 2'd1;
            end
        end else begin
            if (curCounter != counterStrongNotTaken) begin
                nextCounter = curCounter - 2'd1;
            end
        end
    end

    for (genvar lineIdx = 0; lineIdx < lineCount; lineIdx++) begin : genLine
        always_ff @(posedge clk or negedge rstN) begin
            if (!rstN) begin
                lineRegs[lineIdx] <= {lineWidth{counterWeakTaken}};
            end else if (writeHit && lineSel == lineSelBits'(lineIdx)) begin
                lineRegs[lineIdx][entrySel] <= nextCounter;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;   // single-cycle ack.
        end
    end

    // old value, captured at the same edge as any write.
    always_ff @(posedge clk) begin
        if (access) begin
            bus.datR <= curCounter;
        end
    end

endmodule

/* common/wbBus.sv */
`timescale 1ns/1ps

interface wbBus;
    import predictorPkg::*;
    import busPkg::*;

    logic cyc;
    logic stb;
    logic we;
    branchAddrT adr;
    busDataT datW;
    busDataT datR;
    logic ack;

    modport master (
        output cyc, stb, we, adr, datW,
        input  datR, ack
    );

    modport slave (
        input  cyc, stb, we, adr, datW,
        output datR, ack
    );

endinterface

/* common/busPkg.sv */
package busPkg;

    typedef logic [1:0] busDataT;   // counter on read, outcome in bit 0 on write.

    typedef logic masterIdT;

    localparam masterIdT masterLookup = 1'b0;
    localparam masterIdT masterTrainer = 1'b1;

    typedef enum logic [1:0] {
        idle,
        grantLookup,
        grantTrainer
    } arbStateT;

endpackage

/* common/predictorPkg.sv */
package predictorPkg;

    localparam int lookupAddrBits = 6;
    localparam int lineCount = 8;
    localparam int lineWidth = 8;

    // lineCount * lineWidth must equal 2**lookupAddrBits.
    localparam int lineSelBits = $clog2(lineCount);
    localparam int entrySelBits = $clog2(lineWidth);

    typedef logic [lookupAddrBits-1:0] branchAddrT;
    typedef logic [1:0] counterT;
    typedef logic [lineSelBits-1:0] lineSelT;
    typedef logic [entrySelBits-1:0] entrySelT;

    // one table line, entry 0 in the low bits.
    typedef counterT [lineWidth-1:0] lineT;

    localparam counterT counterStrongNotTaken = 2'b00;
    localparam counterT counterWeakTaken = 2'b10;
    localparam counterT counterStrongTaken = 2'b11;

endpackage
